// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_little_computer
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  := *** TEST PASSED ***

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// File: hw/cpu.sv
`default_nettype none

module cpu #(
	parameter int step_div = 64
) (
	input  logic           sysclk,
	input  logic           sysrst,
	input  logic           load_en,
	input  logic           debug_mode,
	input  logic           step_key,
	input  lc_pkg::instr_u instr,
	output lc_pkg::addr_t  pc,
	output lc_pkg::addr_t  data_addr,
	output lc_pkg::word_t  data_wr,
	output logic           data_we,
	input  lc_pkg::word_t  data_rd,
	output logic           halted,
	output lc_pkg::word_t  out_data,
	output logic           out_valid
);

	import lc_pkg::*;

	localparam int div_w = (step_div > 1) ? $clog2(step_div) : 1;

	logic [div_w-1:0] div_cnt;
	logic             div_tick;
	logic             step;

	word_t    regs [4];
	instr_r_t ir;
	instr_i_t ii;
	word_t    rd_val;
	word_t    ra_val;
	word_t    rb_val;
	logic     wb_en;
	word_t    wb_val;
	addr_t    pc_next;

	// Step enable from divider or push button
	assign div_tick = (div_cnt == div_w'(step_div - 1));
	assign step = !load_en && !halted && (debug_mode ? step_key : div_tick);

	// Both views of the same word; rd lines up in each
	assign ir = instr.r;
	assign ii = instr.i;

	assign rd_val = regs[ir.rd];
	assign ra_val = regs[ir.ra];
	assign rb_val = regs[ir.rb];

	assign data_addr = ra_val[addr_width-1:0];
	assign data_wr   = rd_val;
	assign data_we   = step && (ir.opcode == st);
	assign out_valid = step && (ir.opcode == out);

	always_comb begin
		wb_en   = 1'b0;
		wb_val  = ra_val;
		pc_next = pc + addr_t'(1);
		case (ir.opcode)
			add: begin
				wb_en  = 1'b1;
				wb_val = ra_val + rb_val;
			end
			sub: begin
				wb_en  = 1'b1;
				wb_val = ra_val - rb_val;
			end
			and_op: begin
				wb_en  = 1'b1;
				wb_val = ra_val & rb_val;
			end
			or_op: begin
				wb_en  = 1'b1;
				wb_val = ra_val | rb_val;
			end
			ldi: begin
				wb_en  = 1'b1;
				wb_val = word_t'(ii.imm);
			end
			ld: begin
				wb_en  = 1'b1;
				wb_val = data_rd;
			end
			jmp: pc_next = ii.imm;
			bz: begin
				if (rd_val == '0) begin
					pc_next = ii.imm;
				end
			end
			// pc stays on the halt itself
			halt: pc_next = pc;
			default: ;
		endcase
	end

	always_ff @(posedge sysclk) begin
		if (!sysrst || load_en) begin
			div_cnt <= '0;
			pc      <= '0;
			halted  <= 1'b0;
			foreach (regs[i]) begin
				regs[i] <= '0;
			end
		end else begin
			div_cnt <= div_tick ? '0 : div_cnt + 1'b1;
			if (step) begin
				pc <= pc_next;
				if (wb_en) begin
					regs[ir.rd] <= wb_val;
				end
				if (ir.opcode == halt) begin
					halted <= 1'b1;
				end
			end
		end
	end

	// Output value lands the cycle after out_valid
	always_ff @(posedge sysclk) begin
		if (out_valid) begin
			out_data <= rd_val;
		end
	end

	pc_frozen_when_halted: assert property (
		@(posedge sysclk) disable iff (!sysrst || load_en)
		halted |=> $stable(pc)
	);

endmodule

`default_nettype wire

// File: hw/cpu_mem.sv
`default_nettype none

module cpu_mem (
	input  logic              sysclk,
	input  logic              sysrst,
	input  logic              load_en,
	input  lc_pkg::mem_load_t load_in,
	input  lc_pkg::addr_t     pc,
	output lc_pkg::instr_u    instr,
	input  lc_pkg::addr_t     data_addr,
	input  lc_pkg::word_t     data_wr,
	input  logic              data_we,
	output lc_pkg::word_t     data_rd
);

	import lc_pkg::*;

	word_t mem [0:(1 << addr_width) - 1];

	logic  load_q;
	addr_t load_addr;
	logic  wr_en;
	addr_t wr_addr;
	word_t wr_data;

	// Load address counter, restarts on each new load
	always_ff @(posedge sysclk) begin
		if (!sysrst) begin
			load_q    <= 1'b0;
			load_addr <= '0;
		end else begin
			load_q <= load_en;
			if (load_en && !load_q) begin
				load_addr <= '0;
			end else if (load_en && load_in.ready) begin
				load_addr <= load_addr + addr_t'(1);
			end
		end
	end

	// Loader owns the write port while load_en is high
	always_comb begin
		if (load_en) begin
			wr_en   = load_in.ready;
			wr_addr = load_addr;
			wr_data = load_in.word;
		end else begin
			wr_en   = data_we;
			wr_addr = data_addr;
			wr_data = data_wr;
		end
	end

	always_ff @(posedge sysclk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	assign instr   = mem[pc];
	assign data_rd = mem[data_addr];

	// CPU sits in reset for the whole load
	no_store_in_load: assert property (
		@(posedge sysclk) disable iff (!sysrst)
		load_en |-> !data_we
	);

endmodule

`default_nettype wire

// File: hw/lc_pkg.sv
`default_nettype none

package lc_pkg;

	localparam int word_width = 16;
	localparam int addr_width = 8;

	typedef logic [word_width-1:0] word_t;
	typedef logic [addr_width-1:0] addr_t;
	typedef logic [1:0]            reg_idx_t;

	// Opcode sits in the top nibble of every instruction
	typedef enum logic [3:0] {
		add    = 4'h0,
		sub    = 4'h1,
		and_op = 4'h2,
		or_op  = 4'h3,
		ldi    = 4'h4,
		ld     = 4'h5,
		st     = 4'h6,
		jmp    = 4'h7,
		bz     = 4'h8,
		out    = 4'h9,
		halt   = 4'ha
	} opcode_e;

	// Register format, rd <= ra op rb
	typedef struct packed {
		opcode_e  opcode;
		reg_idx_t rd;
		reg_idx_t ra;
		reg_idx_t rb;
		logic [5:0] unused;
	} instr_r_t;

	// Immediate format, 8-bit constant or jump target
	typedef struct packed {
		opcode_e  opcode;
		reg_idx_t rd;
		logic [1:0] unused;
		logic [7:0] imm;
	} instr_i_t;

	typedef union packed {
		instr_r_t r;
		instr_i_t i;
	} instr_u;

	// One received serial frame
	typedef struct packed {
		logic [7:0] data;
		logic       ready;
	} uart_byte_t;

	// Assembled program word headed for memory
	typedef struct packed {
		word_t word;
		logic  ready;
	} mem_load_t;

endpackage

`default_nettype wire

// File: hw/little_computer.sv
`default_nettype none

module little_computer #(
	parameter int baud_div = 434,
	parameter int step_div = 64
) (
	input  logic          sysclk,
	input  logic          sysrst,
	input  logic          rx,
	input  logic          load_en,
	input  logic          debug_mode,
	input  logic          step_key,
	output lc_pkg::addr_t pc,
	output logic          halted,
	output lc_pkg::word_t out_data,
	output logic          out_valid
);

	import lc_pkg::*;

	uart_byte_t rx_byte;
	mem_load_t  load_word;
	instr_u     instr;
	addr_t      data_addr;
	word_t      data_wr;
	word_t      data_rd;
	logic       data_we;

	uart_rx #(
		.baud_div(baud_div)
	) u_uart_rx (
		.sysclk  (sysclk),
		.sysrst  (sysrst),
		.rx      (rx),
		.byte_out(rx_byte)
	);

	uart_word_asm u_word_asm (
		.sysclk  (sysclk),
		.sysrst  (sysrst),
		.load_en (load_en),
		.byte_in (rx_byte),
		.word_out(load_word)
	);

	cpu_mem u_mem (
		.sysclk   (sysclk),
		.sysrst   (sysrst),
		.load_en  (load_en),
		.load_in  (load_word),
		.pc       (pc),
		.instr    (instr),
		.data_addr(data_addr),
		.data_wr  (data_wr),
		.data_we  (data_we),
		.data_rd  (data_rd)
	);

	cpu #(
		.step_div(step_div)
	) u_cpu (
		.sysclk    (sysclk),
		.sysrst    (sysrst),
		.load_en   (load_en),
		.debug_mode(debug_mode),
		.step_key  (step_key),
		.instr     (instr),
		.pc        (pc),
		.data_addr (data_addr),
		.data_wr   (data_wr),
		.data_we   (data_we),
		.data_rd   (data_rd),
		.halted    (halted),
		.out_data  (out_data),
		.out_valid (out_valid)
	);

endmodule

`default_nettype wire

// File: hw/uart_rx.sv
`default_nettype none

module uart_rx #(
	parameter int baud_div = 434
) (
	input  logic               sysclk,
	input  logic               sysrst,
	input  logic               rx,
	output lc_pkg::uart_byte_t byte_out
);

	localparam int cnt_w = (baud_div > 1) ? $clog2(baud_div) : 1;
	localparam int half  = baud_div / 2;

	typedef enum logic [1:0] {
		st_idle,
		st_start,
		st_data,
		st_stop
	} rx_state_e;

	rx_state_e        state;
	logic [1:0]       rx_sync;
	logic             rx_prev;
	logic             rx_s;
	logic [cnt_w-1:0] cnt;
	logic [2:0]       bit_idx;
	logic [7:0]       shreg;
	logic             ready;

	// Two-flop synchronizer on the asynchronous line
	assign rx_s = rx_sync[1];

	always_ff @(posedge sysclk) begin
		if (!sysrst) begin
			rx_sync <= 2'b11;
			rx_prev <= 1'b1;
			state   <= st_idle;
			cnt     <= '0;
			bit_idx <= '0;
			ready   <= 1'b0;
		end else begin
			rx_sync <= {rx_sync[0], rx};
			rx_prev <= rx_s;
			ready   <= 1'b0;
			case (state)
				st_idle: begin
					cnt     <= '0;
					bit_idx <= '0;
					if (rx_prev && !rx_s) begin
						state <= st_start;
					end
				end
				st_start: begin
					if (cnt == cnt_w'(half - 1)) begin
						cnt <= '0;
						// Glitch, not a real start bit
						state <= rx_s ? st_idle : st_data;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				st_data: begin
					if (cnt == cnt_w'(baud_div - 1)) begin
						cnt     <= '0;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7) begin
							state <= st_stop;
						end
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				st_stop: begin
					if (cnt == cnt_w'(baud_div - 1)) begin
						// Low stop bit means framing error, byte dropped
						ready <= rx_s;
						state <= st_idle;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// LSB arrives first, so shift in from the top
	always_ff @(posedge sysclk) begin
		if (state == st_data && cnt == cnt_w'(baud_div - 1)) begin
			shreg <= {rx_s, shreg[7:1]};
		end
	end

	assign byte_out.data  = shreg;
	assign byte_out.ready = ready;

	ready_single_pulse: assert property (
		@(posedge sysclk) disable iff (!sysrst)
		byte_out.ready |=> !byte_out.ready
	);

endmodule

`default_nettype wire

// File: hw/uart_word_asm.sv
`default_nettype none

module uart_word_asm (
	input  logic               sysclk,
	input  logic               sysrst,
	input  logic               load_en,
	input  lc_pkg::uart_byte_t byte_in,
	output lc_pkg::mem_load_t  word_out
);

	logic       load_q;
	logic       second;
	logic       word_ready;
	logic [7:0] hi_byte;
	logic [7:0] lo_byte;

	// Parity toggle, set once the high byte is held
	always_ff @(posedge sysclk) begin
		if (!sysrst) begin
			load_q     <= 1'b0;
			second     <= 1'b0;
			word_ready <= 1'b0;
		end else begin
			load_q     <= load_en;
			word_ready <= 1'b0;
			if (load_en && !load_q) begin
				// New load always starts on a high byte
				second <= 1'b0;
			end else if (byte_in.ready) begin
				second     <= !second;
				word_ready <= second;
			end
		end
	end

	always_ff @(posedge sysclk) begin
		if (byte_in.ready) begin
			if (!second) begin
				hi_byte <= byte_in.data;
			end else begin
				lo_byte <= byte_in.data;
			end
		end
	end

	assign word_out.word  = {hi_byte, lo_byte};
	assign word_out.ready = word_ready;

endmodule

`default_nettype wire

// File: src.f
hw/lc_pkg.sv
hw/uart_rx.sv
hw/uart_word_asm.sv
hw/cpu_mem.sv
hw/cpu.sv
hw/little_computer.sv
verif/tb_little_computer.sv

// File: verif/tb_little_computer.sv
`default_nettype none

module tb_little_computer;

	timeunit 1ns;
	timeprecision 100ps;

	import lc_pkg::*;

	localparam int bit_cycles   = 16;
	localparam int step_div     = 4;
	localparam int p1_len       = 23;
	localparam int p2_len       = 6;
	localparam int halt_steps   = 50;
	localparam int pulse_gap    = 8;
	localparam int frame_cycles = 11 * bit_cycles;
	localparam int load_cycles  = (2 * (p1_len + p2_len) + 1) * frame_cycles + 40;
	localparam int run_cycles   = (p1_len + halt_steps) * step_div + (p2_len + 4) * pulse_gap + 60;
	localparam int cycle_limit  = 2 * load_cycles + run_cycles;

	logic  sysclk;
	logic  sysrst;
	logic  rx;
	logic  load_en;
	logic  debug_mode;
	logic  step_key;
	addr_t pc;
	logic  halted;
	word_t out_data;
	logic  out_valid;

	logic [15:0] lfsr = 16'd58803;
	word_t       prog1 [$];
	word_t       prog2 [$];
	word_t       exp_q [$];
	word_t       exp2 [$];
	word_t       got [$];
	int          step_outs [$];
	addr_t       step_pc [$];
	addr_t       halt_addr;
	logic        cap_next = 1'b0;
	int          cycles = 0;
	int          test_errs = 0;
	int          total_errs = 0;
	int          passed = 0;
	int          failed = 0;

	little_computer #(
		.baud_div(bit_cycles),
		.step_div(step_div)
	) dut (
		.sysclk    (sysclk),
		.sysrst    (sysrst),
		.rx        (rx),
		.load_en   (load_en),
		.debug_mode(debug_mode),
		.step_key  (step_key),
		.pc        (pc),
		.halted    (halted),
		.out_data  (out_data),
		.out_valid (out_valid)
	);

	initial begin
		sysclk = 1'b0;
		forever #10 sysclk = ~sysclk;
	end

	always @(posedge sysclk) begin
		cycles <= cycles + 1;
		if (cycles > cycle_limit) begin
			$display("Timeout: run passed %0d cycles without finishing", cycle_limit);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	// out_data follows out_valid by one cycle
	always @(negedge sysclk) begin
		if (cap_next) begin
			got.push_back(out_data);
		end
		cap_next = out_valid;
	end

	// Galois LFSR, taps 16,14,13,11
	function automatic logic lfsr_bit();
		logic lsb;
		lsb  = lfsr[0];
		lfsr = lfsr >> 1;
		if (lsb) begin
			lfsr = lfsr ^ 16'hb400;
		end
		return lsb;
	endfunction

	function automatic logic [7:0] take_bits(input int n);
		logic [7:0] r;
		r = '0;
		repeat (n) r = {r[6:0], lfsr_bit()};
		return r;
	endfunction

	function automatic word_t reg_format(opcode_e op, reg_idx_t rd, reg_idx_t ra, reg_idx_t rb);
		return {op, rd, ra, rb, 6'b000000};
	endfunction

	function automatic word_t imm_format(opcode_e op, reg_idx_t rd, logic [7:0] imm);
		return {op, rd, 2'b00, imm};
	endfunction

	task automatic tick(input int n);
		repeat (n) @(posedge sysclk);
		#2;
	endtask

	task automatic build_tables();
		logic [7:0] a;
		logic [7:0] b;
		logic [7:0] c;
		logic [7:0] d1;
		logic [7:0] d2;
		logic [7:0] st_addr;
		int         outs;
		a       = take_bits(8);
		b       = take_bits(8);
		st_addr = 8'h80 | take_bits(6);
		c       = take_bits(8);
		d1      = take_bits(8);
		d2      = take_bits(8);
		prog1.push_back(imm_format(ldi, 2'd0, a));
		prog1.push_back(imm_format(ldi, 2'd1, b));
		prog1.push_back(reg_format(add, 2'd2, 2'd0, 2'd1));
		prog1.push_back(imm_format(out, 2'd2, 8'd0));
		prog1.push_back(reg_format(sub, 2'd2, 2'd0, 2'd1));
		prog1.push_back(imm_format(out, 2'd2, 8'd0));
		prog1.push_back(reg_format(and_op, 2'd2, 2'd0, 2'd1));
		prog1.push_back(imm_format(out, 2'd2, 8'd0));
		prog1.push_back(reg_format(or_op, 2'd2, 2'd0, 2'd1));
		prog1.push_back(imm_format(out, 2'd2, 8'd0));
		prog1.push_back(imm_format(ldi, 2'd3, st_addr));
		prog1.push_back(reg_format(st, 2'd2, 2'd3, 2'd0));
		prog1.push_back(imm_format(ldi, 2'd0, 8'd0));
		prog1.push_back(reg_format(ld, 2'd0, 2'd3, 2'd0));
		prog1.push_back(imm_format(out, 2'd0, 8'd0));
		prog1.push_back(imm_format(ldi, 2'd1, 8'd0));
		prog1.push_back(imm_format(bz, 2'd1, 8'd18));
		// Two outputs that must never appear
		prog1.push_back(imm_format(out, 2'd3, 8'd0));
		prog1.push_back(imm_format(jmp, 2'd0, 8'd20));
		prog1.push_back(imm_format(out, 2'd0, 8'd0));
		prog1.push_back(imm_format(ldi, 2'd1, c));
		prog1.push_back(imm_format(out, 2'd1, 8'd0));
		prog1.push_back(imm_format(halt, 2'd0, 8'd0));
		halt_addr = addr_t'(p1_len - 1);
		exp_q.push_back(word_t'(a) + word_t'(b));
		exp_q.push_back(word_t'(a) - word_t'(b));
		exp_q.push_back(word_t'(a & b));
		exp_q.push_back(word_t'(a | b));
		exp_q.push_back(word_t'(a | b));
		exp_q.push_back(word_t'(c));
		prog2.push_back(imm_format(ldi, 2'd0, d1));
		prog2.push_back(imm_format(out, 2'd0, 8'd0));
		prog2.push_back(imm_format(ldi, 2'd1, d2));
		prog2.push_back(reg_format(add, 2'd2, 2'd0, 2'd1));
		prog2.push_back(imm_format(out, 2'd2, 8'd0));
		prog2.push_back(imm_format(halt, 2'd0, 8'd0));
		exp2.push_back(word_t'(d1));
		exp2.push_back(word_t'(d1) + word_t'(d2));
		// Straight-line program, so counts and pc follow step by step
		outs = 0;
		foreach (prog2[k]) begin
			if (prog2[k][15:12] == out) begin
				outs++;
			end
			step_outs.push_back(outs);
			step_pc.push_back((prog2[k][15:12] == halt) ? addr_t'(k) : addr_t'(k + 1));
		end
	endtask

	task automatic send_frame(input logic [7:0] data, input logic stop_bit);
		rx = 1'b0;
		tick(bit_cycles);
		for (int k = 0; k < 8; k++) begin
			rx = data[k];
			tick(bit_cycles);
		end
		rx = stop_bit;
		tick(bit_cycles);
		rx = 1'b1;
		tick(bit_cycles);
	endtask

	// Frame bad_idx goes out once with a low stop bit, then again intact
	task automatic load_program(input word_t words [$], input int bad_idx);
		logic [7:0] part;
		load_en = 1'b1;
		tick(4);
		for (int f = 0; f < 2 * words.size(); f++) begin
			part = (f % 2 == 0) ? words[f / 2][15:8] : words[f / 2][7:0];
			if (f == bad_idx) begin
				send_frame(part, 1'b0);
			end
			send_frame(part, 1'b1);
		end
		tick(4);
		load_en = 1'b0;
	endtask

	task automatic value_err(input string name, input word_t expv, input word_t act);
		$display("ERR %s expected %h actual %h", name, expv, act);
		test_errs++;
	endtask

	task automatic compare_outs(input string name, input int first, input int count);
		for (int i = first; i < first + count; i++) begin
			if (i >= got.size()) begin
				$display("%s: output number %0d never appeared", name, i);
				test_errs++;
			end else if (got[i] !== exp_q[i]) begin
				value_err(name, exp_q[i], got[i]);
			end
		end
	endtask

	task automatic close_test(input string name);
		if (test_errs == 0) begin
			$display("PASS %s", name);
			passed++;
		end else begin
			$display("FAIL %s with %0d errors", name, test_errs);
			failed++;
		end
		total_errs += test_errs;
		test_errs = 0;
	endtask

	initial begin
		int n_before;
		sysrst     = 1'b0;
		rx         = 1'b1;
		load_en    = 1'b1;
		debug_mode = 1'b0;
		step_key   = 1'b0;
		build_tables();
		tick(10);
		sysrst = 1'b1;

		load_program(prog1, -1);
		while (!halted) tick(1);
		tick(4);
		compare_outs("arith", 0, 4);
		close_test("arith");
		compare_outs("memory", 4, 1);
		close_test("memory");
		compare_outs("control", 5, 1);
		if (got.size() != exp_q.size()) begin
			$display("control: %0d outputs seen where %0d were allowed", got.size(), exp_q.size());
			test_errs++;
		end
		close_test("control");

		if (pc !== halt_addr) begin
			value_err("halt_pc", word_t'(halt_addr), word_t'(pc));
		end
		n_before = got.size();
		tick(halt_steps * step_div);
		if (!halted) begin
			$display("halt: halted dropped while the CPU should be stopped");
			test_errs++;
		end
		if (got.size() != n_before) begin
			$display("halt: out_valid fired after the HALT instruction");
			test_errs++;
		end
		if (pc !== halt_addr) begin
			value_err("halt_pc_frozen", word_t'(halt_addr), word_t'(pc));
		end
		close_test("halt");

		// Second program, stepped by hand, high byte of word 1 sent bad first
		got.delete();
		exp_q      = exp2;
		debug_mode = 1'b1;
		load_program(prog2, 2);
		tick(20);
		if (got.size() != 0 || pc !== 8'd0) begin
			$display("debug: CPU advanced without a step_key pulse");
			test_errs++;
		end
		for (int k = 0; k < p2_len; k++) begin
			step_key = 1'b1;
			tick(1);
			step_key = 1'b0;
			tick(pulse_gap);
			if (got.size() != step_outs[k]) begin
				value_err("debug_outs", word_t'(step_outs[k]), word_t'(got.size()));
			end
			if (pc !== step_pc[k]) begin
				value_err("debug_pc", word_t'(step_pc[k]), word_t'(pc));
			end
		end
		if (!halted) begin
			$display("debug: CPU never reached the HALT of the second program");
			test_errs++;
		end
		close_test("reload_debug");

		compare_outs("framing", 0, exp2.size());
		if (got.size() != exp2.size()) begin
			$display("framing: %0d outputs seen where %0d were expected", got.size(), exp2.size());
			test_errs++;
		end
		close_test("framing");

		$display("Tests: %0d passed, %0d failed, %0d errors", passed, failed, total_errs);
		if (failed == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire
